// File: Makefile
# Verilator build and run for the ALU execute lane
# Override any variable on the command line, e.g. make run TOP=aluExecLaneTb

VERILATOR ?= verilator
TOP ?= aluExecLaneTb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= RESULT: PASS

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv test/*.svh)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line appears in the simulator output
run: $(SIM)
	@out="$$($(abspath $(SIM)))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+source
+incdir+test
source/aluPkg.sv
source/aluOpDecode.sv
source/aluAddSub.sv
source/aluLane.sv
source/aluWriteback.sv
source/aluExecLane.sv
test/aluExecLaneTb.sv

// File: source/aluAddSub.sv
/*
	Carry-select adder/subtractor
	Adds each segment for both carry-ins, then selects segment sums
	into two half-width results and one full-width result
*/
`include "aluSettings.svh"

module aluAddSub (
	input  logic [`ALU_DATA_WIDTH-1:0] a,
	input  logic [`ALU_DATA_WIDTH-1:0] b,
	input  logic                       subtract,
	output logic [`ALU_DATA_WIDTH/2:0] sumLo0,
	output logic [`ALU_DATA_WIDTH/2:0] sumLo1,
	output logic [`ALU_DATA_WIDTH/2:0] sumHi0,
	output logic [`ALU_DATA_WIDTH/2:0] sumHi1,
	output logic [`ALU_DATA_WIDTH:0]   sumQ0,
	output logic [`ALU_DATA_WIDTH:0]   sumQ1
);
	localparam int DataW = `ALU_DATA_WIDTH;
	localparam int HalfW = DataW / 2;
	localparam int SegW = `ALU_SEG_WIDTH;
	localparam int SegCount = DataW / SegW;
	localparam int HalfSegs = SegCount / 2;

	logic [DataW-1:0] bIn;
	logic [SegW:0] segSum0 [SegCount];
	logic [SegW:0] segSum1 [SegCount];

	// Subtract is a + ~b with the carry-in picked by the caller
	assign bIn = subtract ? ~b : b;

	// ##################################################
	// Segment sums for carry-in 0 and 1

	for (genvar s = 0; s < SegCount; s++) begin : gSeg
		assign segSum0[s] = {1'b0, a[s*SegW +: SegW]} + {1'b0, bIn[s*SegW +: SegW]};
		assign segSum1[s] = {1'b0, a[s*SegW +: SegW]} + {1'b0, bIn[s*SegW +: SegW]}
			+ {{SegW{1'b0}}, 1'b1};
	end

	// Ripple the segment carries through one half, msb is carry-out
	function automatic logic [HalfW:0] chainHalf(input int first, input logic cin);
		logic carry;
		logic [HalfW:0] res;
		carry = cin;
		res = '0;
		for (int i = 0; i < HalfSegs; i++) begin
			res[i*SegW +: SegW] = carry ? segSum1[first+i][SegW-1:0]
				: segSum0[first+i][SegW-1:0];
			carry = carry ? segSum1[first+i][SegW] : segSum0[first+i][SegW];
		end
		res[HalfW] = carry;
		return res;
	endfunction

	// ##################################################
	// Half and full width results

	always_comb begin
		sumLo0 = chainHalf(0, 1'b0);
		sumLo1 = chainHalf(0, 1'b1);
		sumHi0 = chainHalf(HalfSegs, 1'b0);
		sumHi1 = chainHalf(HalfSegs, 1'b1);

		// Low carry-out picks the upper half for the full-width sum
		sumQ0 = {sumLo0[HalfW] ? sumHi1 : sumHi0, sumLo0[HalfW-1:0]};
		sumQ1 = {sumLo1[HalfW] ? sumHi1 : sumHi0, sumLo1[HalfW-1:0]};
	end

endmodule

// File: source/aluExecLane.sv
/*
	Secondary integer execute lane
	Decoder, datapath and status writeback with one cycle latency
*/
`include "aluSettings.svh"

module aluExecLane (
	input  logic                       clock,
	input  logic                       rst,
	input  logic                       issue,
	input  logic                       hold,
	input  logic [7:0]                 uCmd,
	input  logic [7:0]                 uIxt,
	input  logic [`ALU_DATA_WIDTH-1:0] valRs,
	input  logic [`ALU_DATA_WIDTH-1:0] valRt,
	output logic                       resultValid,
	output logic [`ALU_DATA_WIDTH-1:0] resultVal,
	output logic                       illegalOp,
	output logic                       srT,
	output logic                       srS
);
	import aluPkg::*;

	logic execute;
	logic illegal;
	aluOp op;
	widthMode mode;
	logic newT;
	logic newS;

	aluOpDecode i_aluOpDecode (
		.issue   (issue),
		.hold    (hold),
		.uCmd    (uCmd),
		.uIxt    (uIxt),
		.curT    (srT),
		.execute (execute),
		.op      (op),
		.mode    (mode),
		.illegal (illegal)
	);

	aluLane i_aluLane (
		.clock     (clock),
		.rst       (rst),
		.hold      (hold),
		.execute   (execute),
		.illegal   (illegal),
		.op        (op),
		.mode      (mode),
		.valRs     (valRs),
		.valRt     (valRt),
		.curT      (srT),
		.curS      (srS),
		.laneValid (resultValid),
		.resultVal (resultVal),
		.newT      (newT),
		.newS      (newS),
		.illegalOp (illegalOp)
	);

	// Forwarded status doubles as the visible SR bits
	aluWriteback i_aluWriteback (
		.clock     (clock),
		.rst       (rst),
		.hold      (hold),
		.laneValid (resultValid),
		.newT      (newT),
		.newS      (newS),
		.curT      (srT),
		.curS      (srS)
	);

endmodule

// File: source/aluLane.sv
/*
	ALU lane datapath
	Picks the operation result, applies the width mode and computes
	the next T/S bits, then registers everything under hold
*/
`include "aluSettings.svh"

module aluLane (
	input  logic                       clock,
	input  logic                       rst,
	input  logic                       hold,
	input  logic                       execute,
	input  logic                       illegal,
	input  aluPkg::aluOp               op,
	input  aluPkg::widthMode           mode,
	input  logic [`ALU_DATA_WIDTH-1:0] valRs,
	input  logic [`ALU_DATA_WIDTH-1:0] valRt,
	input  logic                       curT,
	input  logic                       curS,
	output logic                       laneValid,
	output logic [`ALU_DATA_WIDTH-1:0] resultVal,
	output logic                       newT,
	output logic                       newS,
	output logic                       illegalOp
);
	import aluPkg::*;

	localparam int DataW = `ALU_DATA_WIDTH;
	localparam int HalfW = DataW / 2;

	logic subtract;
	logic cinT;
	logic cinS;
	logic [HalfW:0] sumLo0;
	logic [HalfW:0] sumLo1;
	logic [HalfW:0] sumHi0;
	logic [HalfW:0] sumHi1;
	logic [DataW:0] sumQ0;
	logic [DataW:0] sumQ1;
	logic [HalfW:0] addLo;
	logic [HalfW:0] addHi;
	logic [DataW:0] addQ;
	logic [DataW-1:0] quadRes;
	logic [DataW-1:0] packedRes;
	logic [DataW-1:0] nextVal;
	logic nextT;
	logic nextS;

	// ##################################################
	// Adder and carry-in selection

	assign subtract = (op == opSub) || (op == opSbb);

	aluAddSub i_aluAddSub (
		.a        (valRs),
		.b        (valRt),
		.subtract (subtract),
		.sumLo0   (sumLo0),
		.sumLo1   (sumLo1),
		.sumHi0   (sumHi0),
		.sumHi1   (sumHi1),
		.sumQ0    (sumQ0),
		.sumQ1    (sumQ1)
	);

	// T feeds the low half and quad, S the packed high half
	always_comb begin
		case (op)
			opSub: begin
				cinT = 1'b1;
				cinS = 1'b1;
			end
			opAdc: begin
				cinT = curT;
				cinS = curS;
			end
			opSbb: begin
				cinT = !curT;
				cinS = !curS;
			end
			default: begin
				cinT = 1'b0;
				cinS = 1'b0;
			end
		endcase
	end

	assign addLo = cinT ? sumLo1 : sumLo0;
	assign addHi = cinS ? sumHi1 : sumHi0;
	assign addQ = cinT ? sumQ1 : sumQ0;

	// ##################################################
	// Result select, width mode and status

	always_comb begin
		quadRes = addQ[DataW-1:0];
		packedRes = {addHi[HalfW-1:0], addLo[HalfW-1:0]};
		nextT = curT;
		nextS = curS;

		case (op)
			opAnd: begin
				quadRes = valRs & valRt;
				packedRes = quadRes;
			end
			opOr: begin
				quadRes = valRs | valRt;
				packedRes = quadRes;
			end
			opXor: begin
				quadRes = valRs ^ valRt;
				packedRes = quadRes;
			end
			opCselt: begin
				quadRes = curT ? valRs : valRt;
				packedRes = {curS ? valRs[DataW-1:HalfW] : valRt[DataW-1:HalfW],
					quadRes[HalfW-1:0]};
			end
			opAdc: begin
				nextT = (mode == modeQuad) ? addQ[DataW] : addLo[HalfW];
				nextS = (mode == modePacked) ? addHi[HalfW] : curS;
			end
			opSbb: begin
				// Borrow is the inverted carry-out
				nextT = (mode == modeQuad) ? !addQ[DataW] : !addLo[HalfW];
				nextS = (mode == modePacked) ? !addHi[HalfW] : curS;
			end
			default: ;
		endcase

		case (mode)
			modeWordSx: nextVal = {{HalfW{quadRes[HalfW-1]}}, quadRes[HalfW-1:0]};
			modeWordZx: nextVal = {{HalfW{1'b0}}, quadRes[HalfW-1:0]};
			modeQuad: nextVal = quadRes;
			default: nextVal = packedRes;
		endcase
	end

	// ##################################################
	// Output stage

	always_ff @(posedge clock) begin
		if (rst) begin
			laneValid <= 1'b0;
			illegalOp <= 1'b0;
		end else if (!hold) begin
			laneValid <= execute;
			illegalOp <= illegal;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			resultVal <= nextVal;
			newT <= nextT;
			newS <= nextS;
		end
	end

	// Decoder must never hand over an unknown op for execution
	assert property (@(posedge clock) disable iff (rst) execute |-> !$isunknown(op))
		else $error("aluLane: unknown op while executing");

endmodule

// File: source/aluOpDecode.sv
/*
	ALU op decoder
	Accepts a micro-op for this lane, splits the extension byte,
	tests the predicate against T and flags unsupported operations
*/
`include "aluSettings.svh"

module aluOpDecode (
	input  logic             issue,
	input  logic             hold,
	input  logic [7:0]       uCmd,
	input  logic [7:0]       uIxt,
	input  logic             curT,
	output logic             execute,
	output aluPkg::aluOp     op,
	output aluPkg::widthMode mode,
	output logic             illegal
);
	import aluPkg::*;

	logic accepted;
	logic condPass;
	logic legalOp;
	condCode cond;

	always_comb begin
		// uCmd[7:6] holds stage info that this lane ignores
		accepted = issue && !hold && (uCmd[5:0] == `ALU_UCMD_ALU);

		cond = condCode'(uIxt[7:6]);
		mode = widthMode'(uIxt[5:4]);
		op = aluOp'(uIxt[3:0]);

		case (cond)
			ccAl: condPass = 1'b1;
			ccNv: condPass = 1'b0;
			ccCt: condPass = curT;
			default: condPass = !curT;
		endcase

		// Compares, TST, NOR and friends have no datapath here
		case (op)
			opAdd, opSub, opAdc, opSbb: legalOp = 1'b1;
			opAnd, opOr, opXor, opCselt: legalOp = 1'b1;
			default: legalOp = 1'b0;
		endcase

		execute = accepted && condPass && legalOp;
		// An illegal code is reported whatever the predicate says
		illegal = accepted && !legalOp;
	end

endmodule

// File: source/aluPkg.sv
/*
	ALU lane types
	Operation, width mode and condition code encodings taken
	from the extension byte of the micro-op
*/
package aluPkg;

	// Operation field, uIxt[3:0]
	typedef enum logic [3:0] {
		opAdd   = 4'h0,
		opSub   = 4'h1,
		opAdc   = 4'h2,
		opSbb   = 4'h3,
		opAnd   = 4'h5,
		opOr    = 4'h6,
		opXor   = 4'h7,
		opCselt = 4'hF
	} aluOp;

	// Width field, uIxt[5:4] as {quad, zero-extend}
	typedef enum logic [1:0] {
		modeWordSx = 2'b00,
		modeWordZx = 2'b01,
		modeQuad   = 2'b10,
		modePacked = 2'b11
	} widthMode;

	// Predicate field, uIxt[7:6]
	typedef enum logic [1:0] {
		ccAl = 2'b00,
		ccNv = 2'b01,
		ccCt = 2'b10,
		ccCf = 2'b11
	} condCode;

endpackage

// File: source/aluSettings.svh
/*
	ALU execute lane settings
	Data width, carry-select segment width and the micro-op
	command code that routes work to this lane
*/
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Operand and result width
`define ALU_DATA_WIDTH 64

// Carry-select segment width, 8, 16 or 32 all divide a half word
`define ALU_SEG_WIDTH 16

// Command code in uCmd[5:0] that selects the ALU lane
`define ALU_UCMD_ALU 6'h0A

`endif

// File: source/aluWriteback.sv
/*
	ALU status writeback
	Holds the T/S status bits and forwards the lane's pending
	flags until they are committed
*/
module aluWriteback (
	input  logic clock,
	input  logic rst,
	input  logic hold,
	input  logic laneValid,
	input  logic newT,
	input  logic newS,
	output logic curT,
	output logic curS
);
	logic statT;
	logic statS;

	// Commit on the edge that ends the lane result cycle
	always_ff @(posedge clock) begin
		if (rst) begin
			statT <= 1'b0;
			statS <= 1'b0;
		end else if (laneValid && !hold) begin
			statT <= newT;
			statS <= newS;
		end
	end

	// Pending flags win so that ADC/SBB chains see their own carry
	assign curT = laneValid ? newT : statT;
	assign curS = laneValid ? newS : statS;

	assert property (@(posedge clock) disable iff (rst) !$isunknown({curT, curS}))
		else $error("aluWriteback: status bits unknown");

endmodule

// File: test/aluModel.svh
/*
	ALU execute lane reference model
	Expected results and T/S bits from full-width arithmetic,
	plus the LFSR that feeds random stimulus
*/
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Model status bits as seen on srT/srS
logic modelT;
logic modelS;
logic [31:0] lfsrState = 32'h7a61;

// Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
function automatic logic [63:0] takeBits(input int count);
	logic [63:0] bits;
	logic feedback;
	bits = '0;
	for (int i = 0; i < count; i++) begin
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		bits = {bits[62:0], lfsrState[31]};
		lfsrState = {lfsrState[30:0], feedback};
	end
	return bits;
endfunction

function automatic logic isKeptOp(input logic [3:0] op);
	return op inside {opAdd, opSub, opAdc, opSbb, opAnd, opOr, opXor, opCselt};
endfunction

function automatic logic condPasses(input logic [1:0] cond, input logic t);
	case (cond)
		ccAl: return 1'b1;
		ccNv: return 1'b0;
		ccCt: return t;
		default: return !t;
	endcase
endfunction

function automatic logic [63:0] extendWord(input logic [31:0] word, input logic zeroExt);
	return zeroExt ? {32'h0, word} : {{32{word[31]}}, word};
endfunction

// Plain add or subtract, the bit above the operands is carry or borrow
function automatic logic [64:0] arith(input logic [3:0] op, input logic [63:0] a,
	input logic [63:0] b, input logic flag);
	logic [64:0] wa;
	logic [64:0] wb;
	logic [64:0] wf;
	wa = {1'b0, a};
	wb = {1'b0, b};
	wf = {64'h0, flag};
	case (op)
		opAdd: return wa + wb;
		opSub: return wa - wb;
		opAdc: return wa + wb + wf;
		default: return wa - wb - wf;
	endcase
endfunction

function automatic void modelExec(input logic [3:0] op, input logic [1:0] mode,
	input logic [63:0] rs, input logic [63:0] rt, input logic t, input logic s,
	output logic [63:0] res, output logic nt, output logic ns);
	logic [64:0] q;
	logic [64:0] lo;
	logic [64:0] hi;
	logic [63:0] full;
	logic carryOp;
	q = arith(op, rs, rt, t);
	lo = arith(op, {32'h0, rs[31:0]}, {32'h0, rt[31:0]}, t);
	hi = arith(op, {32'h0, rs[63:32]}, {32'h0, rt[63:32]}, s);
	carryOp = (op == opAdc) || (op == opSbb);
	nt = t;
	ns = s;
	if (op == opAnd || op == opOr || op == opXor || op == opCselt) begin
		case (op)
			opAnd: full = rs & rt;
			opOr: full = rs | rt;
			opXor: full = rs ^ rt;
			default: full = t ? rs : rt;
		endcase
		// Packed select takes its high half from S
		if (op == opCselt && mode == modePacked)
			full[63:32] = s ? rs[63:32] : rt[63:32];
		res = mode[1] ? full : extendWord(full[31:0], mode[0]);
	end else begin
		case (mode)
			modeQuad: begin
				res = q[63:0];
				nt = carryOp ? q[64] : t;
			end
			modePacked: begin
				res = {hi[31:0], lo[31:0]};
				nt = carryOp ? lo[32] : t;
				ns = carryOp ? hi[32] : s;
			end
			default: begin
				res = extendWord(lo[31:0], mode[0]);
				nt = carryOp ? lo[32] : t;
			end
		endcase
	end
endfunction

`endif

// File: test/aluExecLaneTb.sv
/*
	ALU execute lane testbench
	Random micro-ops under random hold, checked every cycle
	against the reference model
*/
`include "aluSettings.svh"

module aluExecLaneTb;
	import aluPkg::*;

	localparam int RandomCycles = 4000;
	localparam int ValidTimeout = 8;

	logic clock;
	logic rst;
	logic issue;
	logic hold;
	logic [7:0] uCmd;
	logic [7:0] uIxt;
	logic [63:0] valRs;
	logic [63:0] valRt;
	logic resultValid;
	logic [63:0] resultVal;
	logic illegalOp;
	logic srT;
	logic srS;

	// Expected outputs after the last rising edge
	logic expValid;
	logic expIllegal;
	logic [63:0] expVal;

	`include "aluModel.svh"

	aluExecLane i_aluExecLane (
		.clock       (clock),
		.rst         (rst),
		.issue       (issue),
		.hold        (hold),
		.uCmd        (uCmd),
		.uIxt        (uIxt),
		.valRs       (valRs),
		.valRt       (valRt),
		.resultValid (resultValid),
		.resultVal   (resultVal),
		.illegalOp   (illegalOp),
		.srT         (srT),
		.srS         (srS)
	);

	always #10 clock = ~clock;

	// ##################################################
	// Checking

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected)
			else failRun($sformatf("Error %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic checkOutputs(input string testName);
		checkValue({testName, " resultValid"}, {63'h0, expValid}, {63'h0, resultValid});
		checkValue({testName, " illegalOp"}, {63'h0, expIllegal}, {63'h0, illegalOp});
		checkValue({testName, " srT"}, {63'h0, modelT}, {63'h0, srT});
		checkValue({testName, " srS"}, {63'h0, modelS}, {63'h0, srS});
		if (expValid)
			checkValue({testName, " resultVal"}, expVal, resultVal);
	endtask

	// Next expected outputs for the inputs now on the pins
	task automatic predict();
		logic accepted;
		logic [63:0] res;
		logic nt;
		logic ns;
		if (!hold) begin
			accepted = issue && (uCmd[5:0] == `ALU_UCMD_ALU);
			expIllegal = accepted && !isKeptOp(uIxt[3:0]);
			expValid = accepted && isKeptOp(uIxt[3:0]) && condPasses(uIxt[7:6], modelT);
			if (expValid) begin
				modelExec(uIxt[3:0], uIxt[5:4], valRs, valRt, modelT, modelS, res, nt, ns);
				expVal = res;
				modelT = nt;
				modelS = ns;
			end
		end
	endtask

	// ##################################################
	// Stimulus

	function automatic logic [3:0] pickKeptOp(input logic [2:0] idx);
		case (idx)
			3'd0: return opAdd;
			3'd1: return opSub;
			3'd2: return opAdc;
			3'd3: return opSbb;
			3'd4: return opAnd;
			3'd5: return opOr;
			3'd6: return opXor;
			default: return opCselt;
		endcase
	endfunction

	task automatic driveRandom();
		logic [3:0] op;
		logic [1:0] cond;
		hold = (takeBits(3) == 64'd0);
		issue = (takeBits(3) != 64'd0);
		// Now and then a command for another lane
		if (takeBits(4) == 64'd0)
			uCmd = 8'(takeBits(8));
		else
			uCmd = {2'(takeBits(2)), `ALU_UCMD_ALU};
		if (takeBits(4) < 64'd13)
			op = pickKeptOp(3'(takeBits(3)));
		else
			op = 4'(takeBits(4));
		if (takeBits(1) == 64'd1)
			cond = 2'(takeBits(2));
		else
			cond = ccAl;
		uIxt = {cond, 2'(takeBits(2)), op};
		valRs = takeBits(64);
		valRt = takeBits(64);
	endtask

	initial begin
		int waitCount;
		int holdCycles;
		clock = 1'b0;
		rst = 1'b1;
		issue = 1'b0;
		hold = 1'b0;
		uCmd = 8'h00;
		uIxt = 8'h00;
		valRs = 64'h0;
		valRt = 64'h0;
		expValid = 1'b0;
		expIllegal = 1'b0;
		expVal = 64'h0;
		modelT = 1'b0;
		modelS = 1'b0;

		repeat (10) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		checkOutputs("reset");

		for (int cycle = 0; cycle < RandomCycles; cycle++) begin
			driveRandom();
			predict();
			@(negedge clock);
			checkOutputs("random");
		end

		// One idle cycle clears the last result
		issue = 1'b0;
		hold = 1'b0;
		predict();
		@(negedge clock);
		checkOutputs("holdRelease");

		// Park an ADD behind hold, then release it
		hold = 1'b1;
		issue = 1'b1;
		uCmd = {2'b00, `ALU_UCMD_ALU};
		uIxt = {ccAl, modeQuad, opAdd};
		valRs = takeBits(64);
		valRt = takeBits(64);
		holdCycles = 2 + int'(takeBits(3));
		repeat (holdCycles) begin
			@(negedge clock);
			checkOutputs("holdRelease");
		end
		hold = 1'b0;
		predict();
		waitCount = 0;
		while (resultValid !== 1'b1) begin
			@(negedge clock);
			issue = 1'b0;
			waitCount++;
			if (waitCount > ValidTimeout && resultValid !== 1'b1)
				failRun("Timeout waiting for resultValid after hold was released");
		end
		checkOutputs("holdRelease");

		$display("RESULT: PASS");
		$finish;
	end

endmodule
